// ==== include/toy_settings.svh ====
// Datapath width, register count, field-position and absolute-base macros
`ifndef TOY_SETTINGS_SVH
`define TOY_SETTINGS_SVH

// Datapath and register file
`define TOY_XLEN      32
`define TOY_NREGS     32
`define TOY_RIDX_W    5
`define TOY_AW        30
`define TOY_IMM17_W   17

// rb index that selects absolute LD/ST addressing
`define TOY_ZERO_BASE 31

// Instruction field positions (LSB of each field)
`define TOY_OPC_LSB   27
`define TOY_RA_LSB    22
`define TOY_RB_LSB    17
`define TOY_RC_LSB    12
`define TOY_I_BIT     5

`endif

// ==== design/toy_pkg.sv ====
// Word and field types, opcode enum, pipeline packets and register-write helper
`default_nettype none

`include "toy_settings.svh"

package toy_pkg;

    // Instruction layout
    //   [31:27] opcode
    //   [26:22] ra, destination or store source
    //   [21:17] rb
    //   [16:12] rc
    //   [16:0]  imm17
    //   [5]     i, shift amount from R[rc] when set
    //   [4:0]   shamt

    typedef logic [`TOY_XLEN-1:0]         word_t;
    typedef logic [`TOY_AW-1:0]           waddr_t;
    typedef logic [`TOY_RIDX_W-1:0]       ridx_t;
    typedef logic [`TOY_IMM17_W-1:0]      imm17_t;
    typedef logic [$clog2(`TOY_XLEN)-1:0] shamt_t;

    // Anything not listed is decoded as OP_NOP
    typedef enum logic [4:0] {
        OP_ADDI = 5'd0,
        OP_ANDI = 5'd1,
        OP_ORI  = 5'd2,
        OP_MOVI = 5'd3,
        OP_ADD  = 5'd4,
        OP_SUB  = 5'd5,
        OP_NEG  = 5'd6,
        OP_NOT  = 5'd7,
        OP_AND  = 5'd8,
        OP_OR   = 5'd9,
        OP_XOR  = 5'd10,
        OP_LSR  = 5'd11,
        OP_ASR  = 5'd12,
        OP_SHL  = 5'd13,
        OP_ROR  = 5'd14,
        OP_NOP  = 5'd15,
        OP_LD   = 5'd19,
        OP_ST   = 5'd21
    } opcode_e;

    typedef struct packed {
        logic    valid;
        opcode_e opcode;
        ridx_t   rd;
        word_t   rb_val;
        word_t   op2_val;
        word_t   st_data;
        imm17_t  imm17;
        logic    sel_rc;
        shamt_t  shamt;
        logic    abs_addr;
    } dec_ex_t;

    typedef struct packed {
        logic    valid;
        opcode_e opcode;
        ridx_t   rd;
        word_t   result;
        word_t   st_data;
    } ex_mem_t;

    typedef struct packed {
        logic  wr;
        ridx_t rd;
    } stage_tag_t;

    typedef struct packed {
        logic  we;
        ridx_t idx;
        word_t data;
    } rf_write_t;

    // ALU ops and LD update ra
    function automatic logic op_writes_reg(opcode_e op);
        return op inside {[OP_ADDI:OP_ROR], OP_LD};
    endfunction

endpackage

`default_nettype wire

// ==== design/toy_fetch.sv ====
// Program counter, instruction request and decode-valid flag
`timescale 1ns/1ns
`default_nettype none

module toy_fetch (
    input  logic            CLK_i,
    input  logic            RSTN_i,
    input  logic            stall_i,
    output logic            ireq_o,
    output toy_pkg::waddr_t iaddr_o,
    output logic            dec_valid_o
);
    import toy_pkg::*;

    logic   ireq_q;
    logic   dec_valid_q;
    waddr_t dec_addr_q;

    // Word address for the next INSTR
    always_comb begin
        if (!dec_valid_q)
            iaddr_o = '0;
        else if (stall_i)
            iaddr_o = dec_addr_q;
        else
            iaddr_o = dec_addr_q + 1'b1;
    end

    always_ff @(posedge CLK_i or negedge RSTN_i) begin
        if (!RSTN_i) begin
            ireq_q      <= 1'b0;
            dec_valid_q <= 1'b0;
            dec_addr_q  <= '0;
        end else begin
            ireq_q      <= 1'b1;
            dec_valid_q <= ireq_q;
            // Track the address whose word shows up on INSTR
            if (ireq_q)
                dec_addr_q <= iaddr_o;
        end
    end

    assign ireq_o      = ireq_q;
    assign dec_valid_o = dec_valid_q;

endmodule

`default_nettype wire

// ==== design/toy_regfile.sv ====
// 32-entry register file, two asynchronous read ports and one write port
`timescale 1ns/1ns
`default_nettype none

`include "toy_settings.svh"

module toy_regfile (
    input  logic               CLK_i,
    input  logic               RSTN_i,
    input  toy_pkg::rf_write_t wr_i,
    input  toy_pkg::ridx_t     raddr0_i,
    input  toy_pkg::ridx_t     raddr1_i,
    output toy_pkg::word_t     rdata0_o,
    output toy_pkg::word_t     rdata1_o
);
    import toy_pkg::*;

    word_t regs [`TOY_NREGS];

    // Write lands at the edge, reads see it next cycle
    always_ff @(posedge CLK_i or negedge RSTN_i) begin
        if (!RSTN_i) begin
            for (int i = 0; i < `TOY_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we) begin
            regs[wr_i.idx] <= wr_i.data;
        end
    end

    // No write-through path
    assign rdata0_o = regs[raddr0_i];
    assign rdata1_o = regs[raddr1_i];

endmodule

`default_nettype wire

// ==== design/toy_decode.sv ====
// Field extraction, source selection, hazard interlock and decode/execute register
`timescale 1ns/1ns
`default_nettype none

`include "toy_settings.svh"

module toy_decode (
    input  logic                CLK_i,
    input  logic                RSTN_i,
    input  toy_pkg::word_t      instr_i,
    input  logic                dec_valid_i,
    output toy_pkg::ridx_t      raddr0_o,
    output toy_pkg::ridx_t      raddr1_o,
    input  toy_pkg::word_t      rdata0_i,
    input  toy_pkg::word_t      rdata1_i,
    input  toy_pkg::stage_tag_t ex_tag_i,
    input  toy_pkg::rf_write_t  wb_i,
    output logic                stall_o,
    output toy_pkg::dec_ex_t    dec_ex_o
);
    import toy_pkg::*;

    localparam dec_ex_t DEC_BUBBLE = '{opcode: OP_NOP, default: '0};

    logic [$bits(opcode_e)-1:0] op_raw;
    opcode_e    op;
    ridx_t      ra;
    ridx_t      rb;
    ridx_t      rc;
    logic       sel_rc;
    logic       is_st;
    logic       rb_abs;
    logic       use_rb;
    logic       use_p1;
    logic       hit_rb;
    logic       hit_p1;
    stage_tag_t own_tag;
    stage_tag_t wb_tag;
    dec_ex_t    dec_ex_d;
    dec_ex_t    dec_ex_q;

    ////////////////////////////////////////
    // Fields
    ////////////////////////////////////////
    assign op_raw = instr_i[`TOY_OPC_LSB +: $bits(opcode_e)];
    assign ra     = instr_i[`TOY_RA_LSB +: `TOY_RIDX_W];
    assign rb     = instr_i[`TOY_RB_LSB +: `TOY_RIDX_W];
    assign rc     = instr_i[`TOY_RC_LSB +: `TOY_RIDX_W];
    assign sel_rc = instr_i[`TOY_I_BIT];
    assign rb_abs = (rb == ridx_t'(`TOY_ZERO_BASE));
    assign is_st  = (op == OP_ST);

    // Unsupported opcodes fall to NOP
    always_comb begin
        if (op_raw <= OP_ROR || op_raw == OP_LD || op_raw == OP_ST)
            op = opcode_e'(op_raw);
        else
            op = OP_NOP;
    end

    // Port 0 always reads rb, port 1 reads ra for stores
    assign raddr0_o = rb;
    assign raddr1_o = is_st ? ra : rc;

    // Which ports the opcode actually reads
    always_comb begin
        use_rb = 1'b0;
        use_p1 = 1'b0;
        case (op)
            OP_ADDI, OP_ANDI, OP_ORI: use_rb = 1'b1;
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                use_rb = 1'b1;
                use_p1 = 1'b1;
            end
            OP_NEG, OP_NOT: use_p1 = 1'b1;
            OP_LSR, OP_ASR, OP_SHL, OP_ROR: begin
                use_rb = 1'b1;
                use_p1 = sel_rc;
            end
            OP_LD: use_rb = !rb_abs;
            OP_ST: begin
                // Base form also needs rb
                use_rb = !rb_abs;
                use_p1 = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Interlock
    ////////////////////////////////////////
    function automatic logic tag_hit(stage_tag_t tag, ridx_t idx);
        return tag.wr && (tag.rd == idx);
    endfunction

    assign own_tag.wr = dec_ex_q.valid && op_writes_reg(dec_ex_q.opcode);
    assign own_tag.rd = dec_ex_q.rd;
    assign wb_tag.wr  = wb_i.we;
    assign wb_tag.rd  = wb_i.idx;

    assign hit_rb = tag_hit(own_tag, rb) || tag_hit(ex_tag_i, rb) || tag_hit(wb_tag, rb);
    assign hit_p1 = tag_hit(own_tag, raddr1_o) || tag_hit(ex_tag_i, raddr1_o)
                  || tag_hit(wb_tag, raddr1_o);

    assign stall_o = dec_valid_i && ((use_rb && hit_rb) || (use_p1 && hit_p1));

    ////////////////////////////////////////
    // Decode/execute register
    ////////////////////////////////////////
    always_comb begin
        dec_ex_d.valid    = 1'b1;
        dec_ex_d.opcode   = op;
        dec_ex_d.rd       = ra;
        dec_ex_d.rb_val   = rdata0_i;
        dec_ex_d.op2_val  = is_st ? '0 : rdata1_i;
        dec_ex_d.st_data  = is_st ? rdata1_i : '0;
        dec_ex_d.imm17    = instr_i[`TOY_IMM17_W-1:0];
        dec_ex_d.sel_rc   = sel_rc;
        dec_ex_d.shamt    = instr_i[$bits(shamt_t)-1:0];
        dec_ex_d.abs_addr = rb_abs;
    end

    always_ff @(posedge CLK_i or negedge RSTN_i) begin
        if (!RSTN_i)
            dec_ex_q <= DEC_BUBBLE;
        else if (!dec_valid_i || stall_o)
            dec_ex_q <= DEC_BUBBLE;
        else
            dec_ex_q <= dec_ex_d;
    end

    assign dec_ex_o = dec_ex_q;

endmodule

`default_nettype wire

// ==== design/toy_execute.sv ====
// ALU, LD/ST address generation and execute/memory register
`timescale 1ns/1ns
`default_nettype none

`include "toy_settings.svh"

module toy_execute (
    input  logic                CLK_i,
    input  logic                RSTN_i,
    input  toy_pkg::dec_ex_t    dec_ex_i,
    output toy_pkg::stage_tag_t ex_tag_o,
    output toy_pkg::ex_mem_t    ex_mem_o
);
    import toy_pkg::*;

    localparam int EXT_W = `TOY_XLEN - `TOY_IMM17_W;

    word_t                  rb_v;
    word_t                  op2;
    word_t                  sext;
    word_t                  zext;
    shamt_t                 sh;
    logic [2*`TOY_XLEN-1:0] rot;
    word_t                  result;
    ex_mem_t                ex_mem_q;

    assign rb_v = dec_ex_i.rb_val;
    assign op2  = dec_ex_i.op2_val;
    assign sext = {{EXT_W{dec_ex_i.imm17[`TOY_IMM17_W-1]}}, dec_ex_i.imm17};
    assign zext = {{EXT_W{1'b0}}, dec_ex_i.imm17};

    // Shift amount from shamt or R[rc][4:0]
    assign sh = dec_ex_i.sel_rc ? op2[$bits(shamt_t)-1:0] : dec_ex_i.shamt;

    // Doubled word, low half is the rotate (zero amount gives rb back)
    assign rot = {rb_v, rb_v} >> sh;

    ////////////////////////////////////////
    // ALU and address
    ////////////////////////////////////////
    always_comb begin
        case (dec_ex_i.opcode)
            OP_ADDI: result = rb_v + sext;
            OP_ANDI: result = rb_v & sext;
            OP_ORI:  result = rb_v | sext;
            OP_MOVI: result = sext;
            OP_ADD:  result = rb_v + op2;
            OP_SUB:  result = rb_v - op2;
            OP_NEG:  result = -op2;
            OP_NOT:  result = ~op2;
            OP_AND:  result = rb_v & op2;
            OP_OR:   result = rb_v | op2;
            OP_XOR:  result = rb_v ^ op2;
            OP_LSR:  result = rb_v >> sh;
            OP_ASR:  result = word_t'($signed(rb_v) >>> sh);
            OP_SHL:  result = rb_v << sh;
            OP_ROR:  result = rot[`TOY_XLEN-1:0];
            // Word address, absolute or base plus offset
            OP_LD, OP_ST: result = dec_ex_i.abs_addr ? zext : rb_v + sext;
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Execute/memory register
    ////////////////////////////////////////
    always_ff @(posedge CLK_i or negedge RSTN_i) begin
        if (!RSTN_i) begin
            ex_mem_q <= '{opcode: OP_NOP, default: '0};
        end else begin
            ex_mem_q.valid   <= dec_ex_i.valid;
            ex_mem_q.opcode  <= dec_ex_i.opcode;
            ex_mem_q.rd      <= dec_ex_i.rd;
            ex_mem_q.result  <= result;
            ex_mem_q.st_data <= dec_ex_i.st_data;
        end
    end

    // Tag for the decode interlock
    assign ex_tag_o.wr = ex_mem_q.valid && op_writes_reg(ex_mem_q.opcode);
    assign ex_tag_o.rd = ex_mem_q.rd;

    assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

// ==== design/toy_mem_wb.sv ====
// Data-port drive, memory/write-back register and write-back select
`timescale 1ns/1ns
`default_nettype none

`include "toy_settings.svh"

module toy_mem_wb (
    input  logic               CLK_i,
    input  logic               RSTN_i,
    input  toy_pkg::ex_mem_t   ex_mem_i,
    output logic               dreq_o,
    output logic               drw_o,
    output toy_pkg::waddr_t    daddr_o,
    output toy_pkg::word_t     dwdata_o,
    input  toy_pkg::word_t     drdata_i,
    output toy_pkg::rf_write_t wb_o
);
    import toy_pkg::*;

    ex_mem_t mem_wb_q;

    ////////////////////////////////////////
    // Data port
    ////////////////////////////////////////
    assign dreq_o   = ex_mem_i.valid && (ex_mem_i.opcode inside {OP_LD, OP_ST});
    assign drw_o    = ex_mem_i.valid && (ex_mem_i.opcode == OP_ST);
    assign daddr_o  = ex_mem_i.result[`TOY_AW-1:0];
    assign dwdata_o = ex_mem_i.st_data;

    // Load data returns one cycle after DREQ
    always_ff @(posedge CLK_i or negedge RSTN_i) begin
        if (!RSTN_i)
            mem_wb_q <= '{opcode: OP_NOP, default: '0};
        else
            mem_wb_q <= ex_mem_i;
    end

    ////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////
    assign wb_o.we   = mem_wb_q.valid && op_writes_reg(mem_wb_q.opcode);
    assign wb_o.idx  = mem_wb_q.rd;
    assign wb_o.data = (mem_wb_q.opcode == OP_LD) ? drdata_i : mem_wb_q.result;

endmodule

`default_nettype wire

// ==== design/toy_core.sv ====
// Top level connecting fetch, register file, decode, execute and memory/write-back
`timescale 1ns/1ns
`default_nettype none

module toy_core (
    input  logic            CLK_i,
    input  logic            RSTN_i,
    output logic            IREQ_o,
    output toy_pkg::waddr_t IADDR_o,
    input  toy_pkg::word_t  INSTR_i,
    output logic            DREQ_o,
    output logic            DRW_o,
    output toy_pkg::waddr_t DADDR_o,
    output toy_pkg::word_t  DWDATA_o,
    input  toy_pkg::word_t  DRDATA_i
);
    import toy_pkg::*;

    logic       stall;
    logic       dec_valid;
    ridx_t      raddr0;
    ridx_t      raddr1;
    word_t      rdata0;
    word_t      rdata1;
    stage_tag_t ex_tag;
    rf_write_t  wb;
    dec_ex_t    dec_ex;
    ex_mem_t    ex_mem;

    toy_fetch u_fetch (
        .CLK_i       (CLK_i),
        .RSTN_i      (RSTN_i),
        .stall_i     (stall),
        .ireq_o      (IREQ_o),
        .iaddr_o     (IADDR_o),
        .dec_valid_o (dec_valid)
    );

    // Written from the write-back stage
    toy_regfile u_regfile (
        .CLK_i    (CLK_i),
        .RSTN_i   (RSTN_i),
        .wr_i     (wb),
        .raddr0_i (raddr0),
        .raddr1_i (raddr1),
        .rdata0_o (rdata0),
        .rdata1_o (rdata1)
    );

    toy_decode u_decode (
        .CLK_i       (CLK_i),
        .RSTN_i      (RSTN_i),
        .instr_i     (INSTR_i),
        .dec_valid_i (dec_valid),
        .raddr0_o    (raddr0),
        .raddr1_o    (raddr1),
        .rdata0_i    (rdata0),
        .rdata1_i    (rdata1),
        .ex_tag_i    (ex_tag),
        .wb_i        (wb),
        .stall_o     (stall),
        .dec_ex_o    (dec_ex)
    );

    toy_execute u_execute (
        .CLK_i    (CLK_i),
        .RSTN_i   (RSTN_i),
        .dec_ex_i (dec_ex),
        .ex_tag_o (ex_tag),
        .ex_mem_o (ex_mem)
    );

    toy_mem_wb u_mem_wb (
        .CLK_i    (CLK_i),
        .RSTN_i   (RSTN_i),
        .ex_mem_i (ex_mem),
        .dreq_o   (DREQ_o),
        .drw_o    (DRW_o),
        .daddr_o  (DADDR_o),
        .dwdata_o (DWDATA_o),
        .drdata_i (DRDATA_i),
        .wb_o     (wb)
    );

endmodule

`default_nettype wire

// ==== tests/toy_checker.sv ====
// Port-protocol assertions for toy_core and their bind
`timescale 1ns/1ns
`default_nettype none

module toy_checker (
    input logic            CLK_i,
    input logic            RSTN_i,
    input logic            ireq_i,
    input toy_pkg::waddr_t iaddr_i,
    input logic            dreq_i,
    input logic            drw_i
);

    // A write is always part of a request
    a_drw_dreq: assert property (@(posedge CLK_i) disable iff (!RSTN_i) drw_i |-> dreq_i)
        else $error("DRW_o high without DREQ_o");

    // Sampled mid-cycle so the asynchronous reset has settled
    a_reset_idle: assert property (@(negedge CLK_i) !RSTN_i |-> !ireq_i && !dreq_i && !drw_i)
        else $error("request line high while reset is held");

    // Fetch either holds or steps by one word
    a_iaddr_step: assert property (@(posedge CLK_i) disable iff (!RSTN_i)
        ireq_i && $past(ireq_i) |-> iaddr_i == $past(iaddr_i) || iaddr_i == $past(iaddr_i) + 1'b1)
        else $error("IADDR_o jumped by more than one word");

    a_dreq_known: assert property (@(posedge CLK_i) disable iff (!RSTN_i) !$isunknown(dreq_i))
        else $error("DREQ_o unknown after reset");

endmodule

bind toy_core toy_checker u_toy_checker (
    .CLK_i   (CLK_i),
    .RSTN_i  (RSTN_i),
    .ireq_i  (IREQ_o),
    .iaddr_i (IADDR_o),
    .dreq_i  (DREQ_o),
    .drw_i   (DRW_o)
);

`default_nettype wire

// ==== tests/toy_tb.sv ====
// Clock, reset, memory models, reference model and directed tests for toy_core
`timescale 1ns/1ns
`default_nettype none

`include "toy_settings.svh"

module toy_tb;
    import toy_pkg::*;

    localparam int IMEM_AW       = 10;
    localparam int IMEM_N        = 2 ** IMEM_AW;
    localparam int DMEM_AW       = 8;
    localparam int DMEM_N        = 2 ** DMEM_AW;
    localparam int STORE_TIMEOUT = 400;

    logic   CLK;
    logic   RSTN;
    logic   ireq;
    waddr_t iaddr;
    word_t  instr;
    logic   dreq;
    logic   drw;
    waddr_t daddr;
    word_t  dwdata;
    word_t  drdata;

    word_t       imem [IMEM_N];
    word_t       dmem [DMEM_N];
    word_t       dinit [DMEM_N];
    int          prog_len;
    logic [31:0] rng;
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    waddr_t      exp_addr [$];
    word_t       exp_data [$];
    waddr_t      got_addr [$];
    word_t       got_data [$];

    toy_core u_toy_core (
        .CLK_i    (CLK),
        .RSTN_i   (RSTN),
        .IREQ_o   (ireq),
        .IADDR_o  (iaddr),
        .INSTR_i  (instr),
        .DREQ_o   (dreq),
        .DRW_o    (drw),
        .DADDR_o  (daddr),
        .DWDATA_o (dwdata),
        .DRDATA_i (drdata)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////
    // Ports sampled mid-cycle and answered 1 ns after the next edge
    initial begin : mem_model
        logic   ireq_s;
        waddr_t iaddr_s;
        logic   dreq_s;
        logic   drw_s;
        waddr_t daddr_s;
        word_t  dwdata_s;
        forever begin
            @(negedge CLK);
            ireq_s   = ireq;
            iaddr_s  = iaddr;
            dreq_s   = dreq;
            drw_s    = drw;
            daddr_s  = daddr;
            dwdata_s = dwdata;
            if (dreq_s && drw_s) begin
                got_addr.push_back(daddr_s);
                got_data.push_back(dwdata_s);
            end
            @(posedge CLK);
            #1;
            if (ireq_s)
                instr = imem[iaddr_s[IMEM_AW-1:0]];
            if (dreq_s && drw_s)
                dmem[daddr_s[DMEM_AW-1:0]] = dwdata_s;
            else if (dreq_s)
                drdata = dmem[daddr_s[DMEM_AW-1:0]];
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic word_t xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic word_t enc_imm(logic [4:0] op, int ra, int rb, logic [16:0] imm);
        return {op, ridx_t'(ra), ridx_t'(rb), imm};
    endfunction

    function automatic word_t enc_reg(logic [4:0] op, int ra, int rb, int rc, logic i, int sh);
        return {op, ridx_t'(ra), ridx_t'(rb), ridx_t'(rc), 6'b0, i, shamt_t'(sh)};
    endfunction

    task automatic emit(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic store_abs(int src, int addr);
        emit(enc_imm(OP_ST, src, `TOY_ZERO_BASE, 17'(addr)));
    endtask

    // NOP fill carries the address and the data fill hashes it
    task automatic new_program();
        prog_len = 0;
        for (int a = 0; a < IMEM_N; a++)
            imem[a] = {OP_NOP, 27'(a)};
        for (int a = 0; a < DMEM_N; a++)
            dinit[a] = 32'(a) * 32'h0100_0193 + 32'hc0de_0000;
    endtask

    task automatic check_word(string sig, word_t exp, word_t got);
        check_cnt++;
        assert (got === exp) else begin
            $display("ERROR %0t %s expected %h got %h", $time, sig, exp, got);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    // Runs the program in order and lists the stores it makes
    task automatic model_stores();
        word_t      r [`TOY_NREGS];
        word_t      m [DMEM_N];
        word_t      w;
        logic [4:0] op;
        ridx_t      ra;
        ridx_t      rb;
        ridx_t      rc;
        word_t      se;
        word_t      a;
        word_t      v;
        int         sa;
        logic       wr;
        m = dinit;
        foreach (r[k])
            r[k] = '0;
        exp_addr.delete();
        exp_data.delete();
        for (int pc = 0; pc < prog_len; pc++) begin
            w  = imem[pc];
            op = w[31:27];
            ra = w[26:22];
            rb = w[21:17];
            rc = w[16:12];
            se = {{15{w[16]}}, w[16:0]};
            sa = w[5] ? int'(r[rc][4:0]) : int'(w[4:0]);
            a  = (rb == ridx_t'(`TOY_ZERO_BASE)) ? {15'b0, w[16:0]} : r[rb] + se;
            wr = 1'b1;
            v  = '0;
            case (op)
                OP_ADDI: v = r[rb] + se;
                OP_ANDI: v = r[rb] & se;
                OP_ORI:  v = r[rb] | se;
                OP_MOVI: v = se;
                OP_ADD:  v = r[rb] + r[rc];
                OP_SUB:  v = r[rb] - r[rc];
                OP_NEG:  v = 32'd0 - r[rc];
                OP_NOT:  v = ~r[rc];
                OP_AND:  v = r[rb] & r[rc];
                OP_OR:   v = r[rb] | r[rc];
                OP_XOR:  v = r[rb] ^ r[rc];
                OP_LSR:  v = r[rb] >> sa;
                OP_ASR:  v = $signed(r[rb]) >>> sa;
                OP_SHL:  v = r[rb] << sa;
                OP_ROR:  v = (sa == 0) ? r[rb] : (r[rb] >> sa) | (r[rb] << (32 - sa));
                OP_LD:   v = m[a[DMEM_AW-1:0]];
                OP_ST: begin
                    exp_addr.push_back(a[`TOY_AW-1:0]);
                    exp_data.push_back(r[ra]);
                    m[a[DMEM_AW-1:0]] = r[ra];
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr)
                r[ra] = v;
        end
    endtask

    ////////////////////////////////////////
    // Run one program and compare stores
    ////////////////////////////////////////
    task automatic run_program(string name);
        int cycles;
        int errs_before;
        errs_before = err_cnt;
        model_stores();
        @(posedge CLK);
        #1;
        RSTN = 1'b0;
        @(negedge CLK);
        dmem = dinit;
        got_addr.delete();
        got_data.delete();
        repeat (10) @(posedge CLK);
        #1;
        RSTN = 1'b1;
        cycles = 0;
        while (got_addr.size() < exp_addr.size() && cycles < STORE_TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        if (got_addr.size() < exp_addr.size()) begin
            $display("ERROR %0t %s timed out with %0d of %0d stores seen", $time, name,
                     got_addr.size(), exp_addr.size());
            err_cnt++;
        end
        // Drain so that a late extra store shows up
        repeat (16) @(posedge CLK);
        check_cnt++;
        assert (got_addr.size() == exp_addr.size()) else begin
            $display("ERROR %0t %s made %0d stores where %0d were expected", $time, name,
                     got_addr.size(), exp_addr.size());
            err_cnt++;
        end
        for (int k = 0; k < exp_addr.size() && k < got_addr.size(); k++) begin
            check_word($sformatf("DADDR_o[%0d]", k), 32'(exp_addr[k]), 32'(got_addr[k]));
            check_word($sformatf("DWDATA_o[%0d]", k), exp_data[k], got_data[k]);
        end
        test_cnt++;
        $display("%-10s %0d stores, %s", name, exp_addr.size(),
                 (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic imm_ops();
        opcode_e ops [4] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_MOVI};
        word_t   w;
        new_program();
        emit(enc_imm(OP_MOVI, 1, 0, 17'h1ffff));
        emit(enc_imm(OP_MOVI, 2, 0, 17'h0abcd));
        emit(enc_imm(OP_ADDI, 3, 1, 17'h10000));
        emit(enc_imm(OP_ANDI, 4, 2, 17'h1ff0f));
        emit(enc_imm(OP_ORI, 5, 2, 17'h10000));
        emit(enc_imm(OP_ORI, 6, 1, 17'h00042));
        for (int k = 1; k <= 6; k++)
            store_abs(k, 100 + k);
        // Random immediates of either sign on a positive base
        for (int k = 0; k < 8; k++) begin
            w = xorshift();
            emit(enc_imm(ops[k % 4], 7, 2, w[16:0]));
            store_abs(7, 110 + k);
        end
        run_program("alu_imm");
    endtask

    task automatic reg_ops();
        opcode_e ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        new_program();
        for (int k = 0; k < 4; k++) begin
            dinit[10 + k] = xorshift();
            emit(enc_imm(OP_LD, k + 1, `TOY_ZERO_BASE, 17'(10 + k)));
        end
        for (int k = 0; k < 5; k++)
            emit(enc_reg(ops[k], 5 + k, 1 + k % 4, 4 - k % 4, 1'b0, 0));
        emit(enc_reg(OP_NEG, 10, 0, 3, 1'b0, 0));
        emit(enc_reg(OP_NOT, 11, 0, 2, 1'b0, 0));
        for (int k = 5; k <= 11; k++)
            store_abs(k, 115 + k);
        run_program("alu_reg");
    endtask

    task automatic shift_ops();
        opcode_e ops [4] = '{OP_LSR, OP_ASR, OP_SHL, OP_ROR};
        new_program();
        dinit[40] = xorshift() | 32'h8000_0000;
        dinit[41] = xorshift() & 32'h7fff_ffff;
        // Amount 13, then amount 0, in the low five bits
        dinit[42] = (xorshift() & ~32'h1f) | 32'd13;
        dinit[43] = xorshift() & ~32'h1f;
        for (int k = 0; k < 4; k++)
            emit(enc_imm(OP_LD, k + 1, `TOY_ZERO_BASE, 17'(40 + k)));
        for (int k = 0; k < 4; k++) begin
            emit(enc_reg(ops[k], 10 + 5 * k, 1, 0, 1'b0, 7));
            emit(enc_reg(ops[k], 11 + 5 * k, 1, 0, 1'b0, 0));
            emit(enc_reg(ops[k], 12 + 5 * k, 2, 3, 1'b1, 31));
            emit(enc_reg(ops[k], 13 + 5 * k, 1, 4, 1'b1, 9));
            emit(enc_reg(ops[k], 14 + 5 * k, 1, 0, 1'b0, 31));
            for (int j = 0; j < 5; j++)
                store_abs(10 + 5 * k + j, 140 + 5 * k + j);
        end
        run_program("shift");
    endtask

    task automatic load_use();
        new_program();
        dinit[20] = xorshift();
        dinit[33] = xorshift();
        emit(enc_imm(OP_LD, 1, `TOY_ZERO_BASE, 17'd20));
        emit(enc_reg(OP_ADD, 2, 1, 1, 1'b0, 0));
        store_abs(2, 160);
        emit(enc_imm(OP_MOVI, 5, 0, 17'd30));
        emit(enc_imm(OP_LD, 3, 5, 17'd3));
        emit(enc_reg(OP_XOR, 4, 3, 1, 1'b0, 0));
        // Negative offset, then read the word straight back
        emit(enc_imm(OP_ST, 4, 5, 17'h1fffe));
        emit(enc_imm(OP_LD, 6, 5, 17'h1fffe));
        store_abs(6, 161);
        run_program("load");
    endtask

    task automatic dep_chain();
        word_t w;
        new_program();
        w = xorshift();
        emit(enc_imm(OP_MOVI, 1, 0, w[16:0]));
        emit(enc_imm(OP_ADDI, 2, 1, w[31:15]));
        emit(enc_reg(5'd22, 2, 1, 1, 1'b0, 0));
        emit(enc_reg(OP_SUB, 3, 2, 1, 1'b0, 0));
        emit(enc_reg(OP_SHL, 3, 3, 1, 1'b1, 0));
        store_abs(3, 170);
        emit(enc_reg(5'd17, 3, 3, 3, 1'b0, 0));
        emit(enc_reg(OP_ROR, 4, 3, 0, 1'b0, 9));
        store_abs(4, 171);
        emit(enc_reg(OP_ADD, 4, 4, 2, 1'b0, 0));
        store_abs(4, 171);
        // Unassigned opcode 20 leaves r2 alone
        emit(enc_imm(5'd20, 2, 31, 17'h00005));
        emit(enc_reg(OP_NOT, 5, 0, 4, 1'b0, 0));
        emit(enc_reg(OP_XOR, 6, 5, 2, 1'b0, 0));
        store_abs(6, 172);
        store_abs(2, 173);
        run_program("chain");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        RSTN      = 1'b0;
        instr     = '0;
        drdata    = '0;
        rng       = 32'h646b4d11;
        err_cnt   = 0;
        check_cnt = 0;
        test_cnt  = 0;
        prog_len  = 0;
        imm_ops();
        reg_ops();
        shift_ops();
        load_use();
        dep_chain();
        $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Whole-run limit
    initial begin
        #100_000;
        $display("ERROR simulation did not finish within the time limit");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/toy_pkg.sv
design/toy_fetch.sv
design/toy_regfile.sv
design/toy_decode.sv
design/toy_execute.sv
design/toy_mem_wb.sv
design/toy_core.sv
tests/toy_checker.sv
tests/toy_tb.sv

// ==== Makefile ====
TOP := toy_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
